// File: hdl/intr_pkg.sv
package intr_pkg;

	// number of interrupt sources.
	localparam int num_irq = 5;

	// bit index of each source, also its priority (0 wins).
	localparam int irq_vblank = 0;
	localparam int irq_stat   = 1;
	localparam int irq_timer  = 2;
	localparam int irq_serial = 3;
	localparam int irq_joypad = 4;

	// register low address bytes.
	localparam logic [7:0] addr_if = 8'h0F;
	localparam logic [7:0] addr_ie = 8'hFF;

	// vector of index i is vector_base + vector_step * i.
	localparam logic [7:0] vector_base = 8'h40;
	localparam logic [7:0] vector_step = 8'd8;

	// upper IF bits have no storage and read high.
	localparam logic [2:0] if_unused_ones = 3'b111;

	// equal samples needed before a joypad level is accepted.
	localparam int joy_stable_cycles = 3;

	// IF word, as a bus byte or as named flag fields.
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [2:0] unused;
			logic       joypad;
			logic       serial;
			logic       timer;
			logic       stat;
			logic       vblank;
		} flags;
	} intr_word_u;

endpackage

// File: hdl/joypad_edge.sv
`timescale 1ns/1ps

module joypad_edge (
	input  logic boga1mhz,
	input  logic arst_n,
	input  logic p10,
	input  logic p11,
	input  logic p12,
	input  logic p13,
	output logic joy_pulse,
	output logic wake
);

	import intr_pkg::*;

	localparam int cnt_w = $clog2(joy_stable_cycles);

	logic             any_low;
	logic             sync_1;
	logic             sync_2;
	logic [cnt_w-1:0] stable_cnt;

	// lines are active low, any pressed key pulls one down.
	assign any_low = ~(p10 & p11 & p12 & p13);

	always_ff @(posedge boga1mhz or negedge arst_n) begin
		if (!arst_n) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
		end else begin
			sync_1 <= any_low;
			sync_2 <= sync_1;
		end
	end

	// count samples that differ from the accepted level.
	always_ff @(posedge boga1mhz or negedge arst_n) begin
		if (!arst_n) begin
			stable_cnt <= '0;
			wake       <= 1'b0;
			joy_pulse  <= 1'b0;
		end else begin
			joy_pulse <= 1'b0;
			if (sync_2 != wake) begin
				if (stable_cnt == cnt_w'(joy_stable_cycles - 1)) begin
					stable_cnt <= '0;
					wake       <= sync_2;
					// only a new press raises the interrupt.
					joy_pulse  <= sync_2;
				end else begin
					stable_cnt <= stable_cnt + 1'b1;
				end
			end else begin
				stable_cnt <= '0;
			end
		end
	end

endmodule

// File: hdl/intr_flags.sv
`timescale 1ns/1ps

module intr_flags (
	input  logic                         boga1mhz,
	input  logic                         arst_n,
	input  logic                         src_vblank,
	input  logic                         src_stat,
	input  logic                         src_timer,
	input  logic                         src_serial,
	input  logic                         joy_pulse,
	input  logic                         if_we,
	input  logic [7:0]                   wdata,
	input  logic                         ack_valid,
	input  logic [2:0]                   ack_index,
	output logic [intr_pkg::num_irq-1:0] if_flags
);

	import intr_pkg::*;

	intr_word_u         wr_word;
	logic [num_irq-1:0] wr_bits;
	logic [num_irq-1:0] src_now;
	logic [num_irq-1:0] src_prev;
	logic [num_irq-1:0] src_event;
	logic [num_irq-1:0] flags_d;

	// pick the flag fields out of the written byte.
	assign wr_word.raw = wdata;

	always_comb begin
		wr_bits             = '0;
		wr_bits[irq_vblank] = wr_word.flags.vblank;
		wr_bits[irq_stat]   = wr_word.flags.stat;
		wr_bits[irq_timer]  = wr_word.flags.timer;
		wr_bits[irq_serial] = wr_word.flags.serial;
		wr_bits[irq_joypad] = wr_word.flags.joypad;
	end

	always_comb begin
		src_now             = '0;
		src_now[irq_vblank] = src_vblank;
		src_now[irq_stat]   = src_stat;
		src_now[irq_timer]  = src_timer;
		src_now[irq_serial] = src_serial;
	end

	// level sources set on a rising edge.
	// joypad already arrives as a one cycle pulse.
	always_comb begin
		src_event             = src_now & ~src_prev;
		src_event[irq_joypad] = joy_pulse;
	end

	// write, then acknowledge clear, then source set.
	always_comb begin
		for (int i = 0; i < num_irq; i++) begin
			flags_d[i] = if_we ? wr_bits[i] : if_flags[i];
			if (ack_valid && ack_index == 3'(i)) begin
				flags_d[i] = 1'b0;
			end
			if (src_event[i]) begin
				flags_d[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge boga1mhz or negedge arst_n) begin
		if (!arst_n) begin
			src_prev <= '0;
			if_flags <= '0;
		end else begin
			src_prev <= src_now;
			if_flags <= flags_d;
		end
	end

endmodule

// File: hdl/intr_dispatch.sv
`timescale 1ns/1ps

module intr_dispatch (
	input  logic                         boga1mhz,
	input  logic                         arst_n,
	input  logic                         ie_we,
	input  logic [7:0]                   wdata,
	input  logic [intr_pkg::num_irq-1:0] if_flags,
	output logic [7:0]                   ie_q,
	output logic                         irq_valid,
	output logic [7:0]                   irq_vector,
	input  logic                         irq_ready,
	output logic                         ack_valid,
	output logic [2:0]                   ack_index
);

	import intr_pkg::*;

	logic [num_irq-1:0] pending;
	logic               sel_found;
	logic [2:0]         sel_index;

	// IE keeps all eight bits, only the low five mask.
	always_ff @(posedge boga1mhz or negedge arst_n) begin
		if (!arst_n) begin
			ie_q <= 8'h00;
		end else if (ie_we) begin
			ie_q <= wdata;
		end
	end

	assign pending = if_flags & ie_q[num_irq-1:0];

	// scan downwards so the lowest index is kept last.
	always_comb begin
		sel_found = 1'b0;
		sel_index = 3'd0;
		for (int i = num_irq - 1; i >= 0; i--) begin
			if (pending[i]) begin
				sel_found = 1'b1;
				sel_index = 3'(i);
			end
		end
	end

	assign irq_valid  = sel_found;
	assign irq_vector = vector_base + vector_step * {5'd0, sel_index};

	// the accepted index clears in IF on the same edge.
	assign ack_valid = irq_valid & irq_ready;
	assign ack_index = sel_index;

endmodule

// File: hdl/reg_bus.sv
`timescale 1ns/1ps

module reg_bus (
	input  logic                         boga1mhz,
	input  logic                         arst_n,
	input  logic                         bus_valid,
	input  logic                         bus_write,
	input  logic [7:0]                   bus_addr,
	input  logic [7:0]                   bus_wdata,
	output logic                         bus_ready,
	output logic                         rsp_valid,
	output logic [7:0]                   rsp_rdata,
	input  logic                         rsp_ready,
	input  logic [intr_pkg::num_irq-1:0] if_flags,
	input  logic [7:0]                   ie_q,
	output logic                         if_we,
	output logic                         ie_we,
	output logic [7:0]                   wdata
);

	import intr_pkg::*;

	logic       accept;
	logic       rd_accept;
	intr_word_u if_word;
	logic [7:0] rd_data;

	// a held response blocks new requests.
	assign bus_ready = ~rsp_valid | rsp_ready;
	assign accept    = bus_valid & bus_ready;
	assign rd_accept = accept & ~bus_write;

	assign if_we = accept & bus_write & (bus_addr == addr_if);
	assign ie_we = accept & bus_write & (bus_addr == addr_ie);
	assign wdata = bus_wdata;

	always_comb begin
		if_word.flags.unused = if_unused_ones;
		if_word.flags.joypad = if_flags[irq_joypad];
		if_word.flags.serial = if_flags[irq_serial];
		if_word.flags.timer  = if_flags[irq_timer];
		if_word.flags.stat   = if_flags[irq_stat];
		if_word.flags.vblank = if_flags[irq_vblank];
	end

	always_comb begin
		case (bus_addr)
			addr_if: rd_data = if_word.raw;
			addr_ie: rd_data = ie_q;
			default: rd_data = 8'hFF;
		endcase
	end

	always_ff @(posedge boga1mhz or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid <= 1'b0;
		end else if (rd_accept) begin
			rsp_valid <= 1'b1;
		end else if (rsp_ready) begin
			rsp_valid <= 1'b0;
		end
	end

	// data only moves on an accepted read.
	always_ff @(posedge boga1mhz) begin
		if (rd_accept) begin
			rsp_rdata <= rd_data;
		end
	end

endmodule

// File: hdl/intr_top.sv
`timescale 1ns/1ps

module intr_top (
	input  logic       boga1mhz,
	input  logic       arst_n,
	input  logic       bus_valid,
	input  logic       bus_write,
	input  logic [7:0] bus_addr,
	input  logic [7:0] bus_wdata,
	output logic       bus_ready,
	output logic       rsp_valid,
	output logic [7:0] rsp_rdata,
	input  logic       rsp_ready,
	input  logic       src_vblank,
	input  logic       src_stat,
	input  logic       src_timer,
	input  logic       src_serial,
	input  logic       p10,
	input  logic       p11,
	input  logic       p12,
	input  logic       p13,
	output logic       irq_valid,
	output logic [7:0] irq_vector,
	input  logic       irq_ready,
	output logic       wake
);

	import intr_pkg::*;

	logic               if_we;
	logic               ie_we;
	logic [7:0]         wdata;
	logic [num_irq-1:0] if_flags;
	logic [7:0]         ie_q;
	logic               ack_valid;
	logic [2:0]         ack_index;
	logic               joy_pulse;

	reg_bus u_reg_bus (
		.boga1mhz  (boga1mhz),
		.arst_n    (arst_n),
		.bus_valid (bus_valid),
		.bus_write (bus_write),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_ready (bus_ready),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.rsp_ready (rsp_ready),
		.if_flags  (if_flags),
		.ie_q      (ie_q),
		.if_we     (if_we),
		.ie_we     (ie_we),
		.wdata     (wdata)
	);

	intr_flags u_intr_flags (
		.boga1mhz   (boga1mhz),
		.arst_n     (arst_n),
		.src_vblank (src_vblank),
		.src_stat   (src_stat),
		.src_timer  (src_timer),
		.src_serial (src_serial),
		.joy_pulse  (joy_pulse),
		.if_we      (if_we),
		.wdata      (wdata),
		.ack_valid  (ack_valid),
		.ack_index  (ack_index),
		.if_flags   (if_flags)
	);

	intr_dispatch u_intr_dispatch (
		.boga1mhz   (boga1mhz),
		.arst_n     (arst_n),
		.ie_we      (ie_we),
		.wdata      (wdata),
		.if_flags   (if_flags),
		.ie_q       (ie_q),
		.irq_valid  (irq_valid),
		.irq_vector (irq_vector),
		.irq_ready  (irq_ready),
		.ack_valid  (ack_valid),
		.ack_index  (ack_index)
	);

	joypad_edge u_joypad_edge (
		.boga1mhz  (boga1mhz),
		.arst_n    (arst_n),
		.p10       (p10),
		.p11       (p11),
		.p12       (p12),
		.p13       (p13),
		.joy_pulse (joy_pulse),
		.wake      (wake)
	);

endmodule

// File: testbench/intr_assert.sv
`timescale 1ns/1ps

module intr_assert (
	input logic       boga1mhz,
	input logic       arst_n,
	input logic       bus_ready,
	input logic       rsp_valid,
	input logic       rsp_ready,
	input logic [7:0] rsp_rdata,
	input logic       irq_valid,
	input logic [7:0] irq_vector
);

	import intr_pkg::*;

	localparam logic [7:0] max_offset = 8'(4 * vector_step);

	logic [7:0] vec_offset;

	assign vec_offset = irq_vector - vector_base;

	// held response keeps its data.
	rsp_hold_a: assert property (@(posedge boga1mhz) disable iff (!arst_n)
		(rsp_valid && !rsp_ready) |=> $stable(rsp_rdata))
		else $error("rsp_rdata changed while the response was held");

	// back-pressure on the response stalls the request side.
	bus_stall_a: assert property (@(posedge boga1mhz) disable iff (!arst_n)
		(rsp_valid && !rsp_ready) |-> !bus_ready)
		else $error("bus_ready high while a response was held");

	vector_a: assert property (@(posedge boga1mhz) disable iff (!arst_n)
		irq_valid |-> (irq_vector >= vector_base && vec_offset <= max_offset
			&& (vec_offset % vector_step) == 8'd0))
		else $error("irq_vector outside the vector table");

endmodule

// File: testbench/tb_intr.sv
`timescale 1ns/1ps

module tb_intr;

	localparam int wait_limit = 64;

	logic       boga1mhz;
	logic       arst_n;
	logic       bus_valid;
	logic       bus_write;
	logic [7:0] bus_addr;
	logic [7:0] bus_wdata;
	logic       bus_ready;
	logic       rsp_valid;
	logic [7:0] rsp_rdata;
	logic       rsp_ready;
	logic       src_vblank;
	logic       src_stat;
	logic       src_timer;
	logic       src_serial;
	logic       p10;
	logic       p11;
	logic       p12;
	logic       p13;
	logic       irq_valid;
	logic [7:0] irq_vector;
	logic       irq_ready;
	logic       wake;

	int         seed = 32'h07b0_d83a;
	logic [3:0] src_lvl;
	logic       aborted;
	int         errors;
	int         test_errors;
	int         tests_run;
	int         tests_failed;

	intr_top dut (.*);

	bind intr_top intr_assert u_intr_assert (.*);

	always #5 boga1mhz = ~boga1mhz;

	task automatic abort_run(input string why);
		$display("run stopped: %s", why);
		aborted = 1'b1;
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
		if (got !== exp) begin
			$display("** Error at %0t: %s expected 8'h%02h, got 8'h%02h",
				$time, name, exp, got);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("** Error at %0t: %s expected %0b, got %0b", $time, name, exp, got);
			errors++;
			test_errors++;
		end
	endtask

	task automatic drive_sources();
		src_vblank <= src_lvl[0];
		src_stat   <= src_lvl[1];
		src_timer  <= src_lvl[2];
		src_serial <= src_lvl[3];
	endtask

	// returns at the falling edge before the accepting clock edge.
	task automatic wait_bus_ready();
		int cnt;
		cnt = 0;
		@(negedge boga1mhz);
		while (!bus_ready && !aborted) begin
			if (cnt >= wait_limit) begin
				abort_run("bus_ready never rose");
			end else begin
				cnt++;
				@(negedge boga1mhz);
			end
		end
	endtask

	task automatic wait_rsp_valid();
		int cnt;
		cnt = 0;
		@(negedge boga1mhz);
		while (!rsp_valid && !aborted) begin
			if (cnt >= wait_limit) begin
				abort_run("no read response arrived");
			end else begin
				cnt++;
				@(negedge boga1mhz);
			end
		end
	endtask

	task automatic wait_irq_valid();
		int cnt;
		cnt = 0;
		@(negedge boga1mhz);
		while (!irq_valid && !aborted) begin
			if (cnt >= wait_limit) begin
				abort_run("irq_valid never rose");
			end else begin
				cnt++;
				@(negedge boga1mhz);
			end
		end
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data,
			input logic [3:0] raise);
		@(posedge boga1mhz);
		bus_valid <= 1'b1;
		bus_write <= 1'b1;
		bus_addr  <= addr;
		bus_wdata <= data;
		// sources seen on the same edge as the write.
		src_lvl = src_lvl | raise;
		drive_sources();
		wait_bus_ready();
		@(posedge boga1mhz);
		bus_valid <= 1'b0;
		bus_write <= 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, input logic [7:0] exp);
		int stall;
		stall = $unsigned($random(seed)) % 4;
		@(posedge boga1mhz);
		bus_valid <= 1'b1;
		bus_write <= 1'b0;
		bus_addr  <= addr;
		rsp_ready <= 1'b0;
		wait_bus_ready();
		@(posedge boga1mhz);
		bus_valid <= 1'b0;
		wait_rsp_valid();
		// a held response stalls the request side.
		check_bit("bus_ready", 1'b0, bus_ready);
		repeat (stall) @(posedge boga1mhz);
		@(posedge boga1mhz);
		rsp_ready <= 1'b1;
		@(negedge boga1mhz);
		check_bit("rsp_valid", 1'b1, rsp_valid);
		check_byte("rsp_rdata", exp, rsp_rdata);
		@(posedge boga1mhz);
		rsp_ready <= 1'b0;
	endtask

	task automatic take_irq(input logic [7:0] exp_vector);
		wait_irq_valid();
		@(posedge boga1mhz);
		irq_ready <= 1'b1;
		@(negedge boga1mhz);
		check_bit("irq_valid", 1'b1, irq_valid);
		check_byte("irq_vector", exp_vector, irq_vector);
		@(posedge boga1mhz);
		irq_ready <= 1'b0;
	endtask

	// the next step's first edge is the last sample of the hold.
	task automatic hold_joypad(input logic [3:0] lines, input int cycles);
		@(posedge boga1mhz);
		p10 <= lines[0];
		p11 <= lines[1];
		p12 <= lines[2];
		p13 <= lines[3];
		repeat (cycles - 1) @(posedge boga1mhz);
	endtask

	// chk bit 0 selects irq_valid, bit 1 selects wake.
	task automatic idle_and_check(input int cycles, input logic [1:0] chk, input logic [1:0] exp);
		repeat (cycles) @(posedge boga1mhz);
		@(negedge boga1mhz);
		if (chk[0]) begin
			check_bit("irq_valid", exp[0], irq_valid);
		end
		if (chk[1]) begin
			check_bit("wake", exp[1], wake);
		end
	endtask

	task automatic close_test(input int num);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0d passed", num);
		end else begin
			$display("test %0d failed with %0d errors", num, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	task automatic run_patterns();
		int         fd;
		int         nf;
		string      line;
		logic [7:0] op;
		logic [31:0] fa;
		logic [31:0] fb;
		logic [31:0] fc;
		fd = $fopen("testbench/intr_patterns.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open testbench/intr_patterns.txt");
		end else begin
			while (!aborted && !$feof(fd)) begin
				line = "";
				nf = $fgets(line, fd);
				if (nf > 0 && line.len() > 1 && line[0] != 8'h23) begin
					nf = $sscanf(line, "%c %h %h %h", op, fa, fb, fc);
					if (nf != 4) begin
						abort_run({"bad pattern line: ", line});
					end else begin
						case (op)
							"W": write_reg(fa[7:0], fb[7:0], fc[3:0]);
							"R": read_reg(fa[7:0], fb[7:0]);
							"S": begin
								@(posedge boga1mhz);
								src_lvl = src_lvl | fa[3:0];
								drive_sources();
							end
							"C": begin
								@(posedge boga1mhz);
								src_lvl = src_lvl & ~fa[3:0];
								drive_sources();
							end
							"J": hold_joypad(fa[3:0], int'(fb));
							"A": take_irq(fa[7:0]);
							"N": idle_and_check(int'(fa), fb[1:0], fc[1:0]);
							"T": close_test(int'(fa));
							default: abort_run({"unknown pattern operation: ", line});
						endcase
					end
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		boga1mhz     = 1'b0;
		arst_n       = 1'b0;
		bus_valid    = 1'b0;
		bus_write    = 1'b0;
		bus_addr     = 8'h00;
		bus_wdata    = 8'h00;
		rsp_ready    = 1'b0;
		src_lvl      = 4'h0;
		src_vblank   = 1'b0;
		src_stat     = 1'b0;
		src_timer    = 1'b0;
		src_serial   = 1'b0;
		p10          = 1'b1;
		p11          = 1'b1;
		p12          = 1'b1;
		p13          = 1'b1;
		irq_ready    = 1'b0;
		aborted      = 1'b0;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (16) @(posedge boga1mhz);
		arst_n <= 1'b1;
		run_patterns();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_run > 0 && !aborted) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
hdl/intr_pkg.sv
hdl/joypad_edge.sv
hdl/intr_flags.sv
hdl/intr_dispatch.sv
hdl/reg_bus.sv
hdl/intr_top.sv
testbench/intr_assert.sv
testbench/tb_intr.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_intr
FILELIST  := build.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: testbench/intr_patterns.txt
# op a b c, all hex. W addr data raise_mask, R addr expect, S/C source mask,
# J lines(p13..p10) cycles, A vector, N cycles check_mask {wake,irq}, T test
N 2 3 0
R 0F E0 0
R FF 00 0
T 1 0 0
W FF A5 0
R FF A5 0
W 0F 1F 0
R 0F FF 0
W 0F 0A 0
R 0F EA 0
R 3C FF 0
W FF 00 0
W 0F 00 0
R 0F E0 0
T 2 0 0
S 1 0 0
R 0F E1 0
W 0F 00 0
N 3 0 0
R 0F E0 0
C 1 0 0
S 1 0 0
R 0F E1 0
T 3 0 0
W 0F 00 0
W FF 0B 0
W 0F 0F 0
A 40 0 0
R 0F EE 0
A 48 0 0
A 58 0 0
N 2 1 0
R 0F E4 0
T 4 0 0
W FF 00 0
W 0F 00 0
J E 2 0
J F 8 0
R 0F E0 0
J D 8 0
N 0 2 2
R 0F F0 0
J F 8 0
N 0 2 0
T 5 0 0
W 0F 00 0
C F 0 0
N 2 0 0
W 0F 00 4
R 0F E4 0
T 6 0 0
